/* tests/decode_stim.txt */
# slot0_in slot1_in slot0_exp slot1_exp, all hex
# in = valid, opcode[6:2], funct7[5], funct3   exp = valid, 19-bit control word
240 0C0 E4200 00000 # addi | bubble
242 1B0 E420D 00000 # slti | bubble
243 000 E620D 00000 # sltiu | bubble
244 3F5 E4206 80000 # xori | unknown opcode
246 3C0 E4207 80000 # ori | system, unknown here
247 230 E4208 80000 # andi | fence, unknown here
241 250 E4202 E4200 # slli | auipc
245 2D0 E4204 E4200 # srli | lui
24D 382 E4205 C4600 # srai | reserved branch
249 387 E4200 C660C # undefined shift-imm | bgeu
2C0 386 A0200 C660B # add | bltu
2C8 385 A0201 C660C # sub | bge
2C1 384 A0202 C460B # sll | blt
2C2 381 A020D C460A # slt | bne
2C3 380 A020D C4609 # sltu | beq
2C4 390 A0206 E4C00 # xor | jalr
2C5 3B0 A0204 E5400 # srl | jal
2CD 283 A0205 CC200 # sra | undefined store
2C6 282 A0207 CC230 # or | sw
2C7 281 A0208 CC220 # and | sh
200 280 F4240 CC210 # lb | sb
201 208 F42C0 F4200 # lh | undefined load
202 203 F4340 F4200 # lw | undefined load
204 205 F4280 F4300 # lbu | lhu
205 204 F4300 F4280
203 202 F4200 F4340
208 201 F4200 F42C0
280 200 CC210 F4240
281 2C7 CC220 A0208
282 2C6 CC230 A0207
283 2CD CC200 A0205
3B0 2C5 E5400 A0204
390 2C4 E4C00 A0206
380 2C3 C4609 A020D
381 2C2 C460A A020D
384 2C1 C460B A0202
385 2C8 C660C A0201
386 2C0 C660B A0200
387 249 C660C E4200
382 24D C4600 E4205
2D0 245 E4200 E4204
250 241 E4200 E4202
230 247 80000 E4208
3C0 246 80000 E4207
3F5 244 80000 E4206
000 243 00000 E620D
1B0 242 00000 E420D
0C0 240 00000 E4200
240 240 E4200 E4200 # same insn in both slots
3B0 390 E5400 E4C00 # jal | jalr
000 000 00000 00000 # both bubbles
202 282 F4340 CC230 # lw | sw
385 385 C660C C660C
243 2C3 E620D A020D # only sltiu sets the unsigned type
24D 2CD E4205 A0205
2C8 2C0 A0201 A0200
230 200 80000 F4240
0C0 3C0 00000 80000
205 204 F4300 F4280
2D0 250 E4200 E4200
380 381 C4609 C460A
1B0 3B0 00000 E5400 # invalid jal | valid jal
2C5 245 A0204 E4204
247 2C7 E4208 A0208

/* files.f */
hdl/decode_pkg.sv
hdl/alu_op_decoder.sv
hdl/insn_decoder.sv
hdl/dual_issue_decoder.sv
tests/tb_clock_gen.sv
tests/tb_dual_issue_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dual_issue_decoder \
    -f files.f \
    -o tb_dual_issue_decoder
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_dual_issue_decoder
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit $status
fi

exit 0

/* tests/tb_dual_issue_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_decoder;

    import decode_pkg::*;

    localparam int    RESET_CYCLES  = 16;
    localparam int    SLACK_CYCLES  = 10;       // Margin on top of the vector run
    localparam int    CLK_PERIOD_NS = 20;
    localparam string STIM_FILE     = "tests/decode_stim.txt";

    logic      clk;
    logic      rst_n;
    slot_in_t  insn_0;
    slot_in_t  insn_1;
    slot_out_t out_0;
    slot_out_t out_1;

    slot_in_t  vec_in_0[$];                     // One entry per stim line
    slot_in_t  vec_in_1[$];
    slot_out_t vec_exp_0[$];
    slot_out_t vec_exp_1[$];
    int        num_vec = 0;
    logic      vectors_loaded = 1'b0;

    tb_clock_gen clk_gen (
        .clk (clk)
    );

    dual_issue_decoder dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .insn_0 (insn_0),
        .insn_1 (insn_1),
        .out_0  (out_0),
        .out_1  (out_1)
    );

    // Fills the vector queues, skipping header and blank lines
    task automatic load_vectors();
        int          fd;
        int          n_items;
        int          line_no;
        string       line;
        logic [9:0]  in_0;
        logic [9:0]  in_1;
        logic [19:0] exp_0;
        logic [19:0] exp_1;
        line_no = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Simulation FAILED");
            $fatal(1, "Cannot open the stimulus file %s", STIM_FILE);
        end
        while ($fgets(line, fd) != 0)
        begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            n_items = $sscanf(line, "%h %h %h %h", in_0, in_1, exp_0, exp_1);
            if (n_items != 4)
            begin
                $display("Simulation FAILED");
                $fatal(1, "Stimulus line %0d does not hold four hex fields", line_no);
            end
            vec_in_0.push_back(slot_in_t'(in_0));
            vec_in_1.push_back(slot_in_t'(in_1));
            vec_exp_0.push_back(slot_out_t'(exp_0));
            vec_exp_1.push_back(slot_out_t'(exp_1));
            num_vec++;
        end
        $fclose(fd);
        if (num_vec == 0)
        begin
            $display("Simulation FAILED");
            $fatal(1, "The stimulus file holds no vectors");
        end
    endtask

    // Applies one input pair to both slots
    task automatic drive_pair(input int idx);
        insn_0 = vec_in_0[idx];
        insn_1 = vec_in_1[idx];
    endtask

    // Compares one registered slot with its expected word
    task automatic check_slot(
        input int        slot,
        input string     what,
        input slot_out_t got,
        input slot_out_t exp
    );
        assert (got == exp)
        else
        begin
            $display("ERR %0t: slot %0d %s got %05h expected %05h",
                     $time, slot, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Registered control word mismatch");
        end
    endtask

    // Pair idx is on the inputs, outputs still show the word before it
    task automatic check_held(input int idx);
        slot_out_t held_0;
        slot_out_t held_1;
        held_0 = '0;                            // Reset value ahead of vector 0
        held_1 = '0;
        if (idx > 0)
        begin
            held_0 = vec_exp_0[idx - 1];
            held_1 = vec_exp_1[idx - 1];
        end
        check_slot(0, $sformatf("before edge of vector %0d", idx), out_0, held_0);
        check_slot(1, $sformatf("before edge of vector %0d", idx), out_1, held_1);
    endtask

    initial
    begin
        rst_n  = 1'b0;
        insn_0 = '0;
        insn_1 = '0;
        load_vectors();
        vectors_loaded = 1'b1;
        drive_pair(0);                          // Held through reset
        repeat (RESET_CYCLES) @(negedge clk);
        check_slot(0, "after reset", out_0, '0); // Valid input must not leak
        check_slot(1, "after reset", out_1, '0);
        rst_n = 1'b1;                           // Vector 0 taken at next edge
        for (int i = 1; i <= num_vec; i++)
        begin
            #(CLK_PERIOD_NS / 4);               // Low phase, rising edge still ahead
            check_held(i - 1);
            @(negedge clk);
            check_slot(0, $sformatf("vector %0d", i - 1), out_0, vec_exp_0[i - 1]);
            check_slot(1, $sformatf("vector %0d", i - 1), out_1, vec_exp_1[i - 1]);
            if (i < num_vec)
                drive_pair(i);                  // Next pair in the very next cycle
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Run length known only once the stim file is read
    initial
    begin
        wait (vectors_loaded);
        #((RESET_CYCLES + num_vec + SLACK_CYCLES) * CLK_PERIOD_NS);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog timeout, the vector run did not complete in time");
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 10;         // 20 ns period

    initial
    begin
        clk = 1'b0;                             // First rising edge at 10 ns
        forever
        begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* hdl/dual_issue_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_issue_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decode_pkg::slot_in_t  insn_0,
    input  decode_pkg::slot_in_t  insn_1,
    output decode_pkg::slot_out_t out_0,
    output decode_pkg::slot_out_t out_1
);

    import decode_pkg::*;

    ctrl_t ctrl_0;                              // Combinational words
    ctrl_t ctrl_1;

    insn_decoder dec_0 (
        .op_code     (insn_0.op_code),
        .sub_op_code (insn_0.sub_op_code),
        .ctrl        (ctrl_0)
    );

    insn_decoder dec_1 (
        .op_code     (insn_1.op_code),
        .sub_op_code (insn_1.sub_op_code),
        .ctrl        (ctrl_1)
    );

    // ID/EX boundary, both slots every cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_0 <= '0;
            out_1 <= '0;
        end
        else
        begin
            out_0.valid <= insn_0.valid;
            out_0.ctrl  <= insn_0.valid ? ctrl_0 : '0; // Bubble when invalid
            out_1.valid <= insn_1.valid;
            out_1.ctrl  <= insn_1.valid ? ctrl_1 : '0;
        end
    end

    property p_mem_excl(slot_out_t s);
        @(posedge clk) disable iff (!rst_n)
        !(s.ctrl.mem_read_en && s.ctrl.mem_write_en);
    endproperty

    property p_load_reads(slot_out_t s);
        @(posedge clk) disable iff (!rst_n)
        (s.ctrl.load_type != LD_NONE) |-> s.ctrl.mem_read_en;
    endproperty

    property p_bubble_empty(slot_out_t s);
        @(posedge clk) disable iff (!rst_n)
        !s.valid |-> (s.ctrl == '0);
    endproperty

    a_mem_excl_0   : assert property (p_mem_excl(out_0));
    a_mem_excl_1   : assert property (p_mem_excl(out_1));
    a_load_reads_0 : assert property (p_load_reads(out_0));
    a_load_reads_1 : assert property (p_load_reads(out_1));
    a_bubble_0     : assert property (p_bubble_empty(out_0));
    a_bubble_1     : assert property (p_bubble_empty(out_1));

endmodule

`default_nettype wire

/* hdl/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  decode_pkg::opcode_e             op_code,
    input  logic [decode_pkg::SUB_OP_W-1:0] sub_op_code,
    output decode_pkg::ctrl_t               ctrl
);

    import decode_pkg::*;

    alu_op_e    alu_op;
    logic [2:0] funct3;

    assign funct3 = sub_op_code[2:0];

    alu_op_decoder u_alu_op_decoder (
        .op_code     (op_code),
        .sub_op_code (sub_op_code),
        .alu_op      (alu_op)
    );

    always_comb
    begin
        ctrl        = '0;                       // Unknown opcode stays all zero
        ctrl.alu_op = alu_op;                   // ADD, i.e. zero, for unknown opcodes
        case (op_code)
            OPC_LUI, OPC_AUIPC:
            begin
                ctrl.imm_en      = 1'b1;
                ctrl.rf_write_en = 1'b1;
                ctrl.sign_ext_en = 1'b1;
                ctrl.pc_mode     = PC_NEXT;
            end
            OPC_OP_IMM:
            begin
                ctrl.imm_en            = 1'b1;
                ctrl.rf_write_en       = 1'b1;
                ctrl.sign_ext_en       = 1'b1;
                ctrl.sign_ext_unsigned = (funct3 == 3'b011); // sltiu
                ctrl.pc_mode           = PC_NEXT;
            end
            OPC_OP:
            begin
                ctrl.rf_write_en = 1'b1;        // Both operands from the RF
                ctrl.pc_mode     = PC_NEXT;
            end
            OPC_LOAD:
            begin
                ctrl.imm_en      = 1'b1;
                ctrl.rf_write_en = 1'b1;
                ctrl.mem_read_en = 1'b1;
                ctrl.sign_ext_en = 1'b1;        // Signed even for lbu and lhu
                ctrl.pc_mode     = PC_NEXT;
                case (sub_op_code)
                    4'b0000: ctrl.load_type = LD_LB;
                    4'b0100: ctrl.load_type = LD_LBU;
                    4'b0001: ctrl.load_type = LD_LH;
                    4'b0101: ctrl.load_type = LD_LHU;
                    4'b0010: ctrl.load_type = LD_LW;
                    default: ctrl.load_type = LD_NONE;
                endcase
            end
            OPC_STORE:
            begin
                ctrl.imm_en       = 1'b1;
                ctrl.mem_write_en = 1'b1;       // No RF write for stores
                ctrl.sign_ext_en  = 1'b1;
                ctrl.pc_mode      = PC_NEXT;
                case (funct3)
                    3'b000: ctrl.store_type = ST_SB;
                    3'b001: ctrl.store_type = ST_SH;
                    3'b010: ctrl.store_type = ST_SW;
                    default: ctrl.store_type = ST_NONE;
                endcase
            end
            OPC_JAL:
            begin
                ctrl.imm_en      = 1'b1;
                ctrl.rf_write_en = 1'b1;        // Link register gets PC plus 4
                ctrl.sign_ext_en = 1'b1;
                ctrl.jal_en      = 1'b1;
                ctrl.pc_mode     = PC_JUMP;
            end
            OPC_JALR:
            begin
                ctrl.imm_en      = 1'b1;
                ctrl.rf_write_en = 1'b1;
                ctrl.sign_ext_en = 1'b1;
                ctrl.jalr_en     = 1'b1;
                ctrl.pc_mode     = PC_JUMP;
            end
            OPC_BRANCH:
            begin
                ctrl.imm_en      = 1'b1;
                ctrl.sign_ext_en = 1'b1;
                ctrl.pc_mode     = PC_BRANCH;
                case (funct3)
                    3'b101: ctrl.sign_ext_unsigned = 1'b1; // bge, kept as in the core
                    3'b110: ctrl.sign_ext_unsigned = 1'b1; // bltu
                    3'b111: ctrl.sign_ext_unsigned = 1'b1; // bgeu
                    default: ctrl.sign_ext_unsigned = 1'b0;
                endcase
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu_op_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_op_decoder (
    input  decode_pkg::opcode_e             op_code,
    input  logic [decode_pkg::SUB_OP_W-1:0] sub_op_code,
    output decode_pkg::alu_op_e             alu_op
);

    import decode_pkg::*;

    logic [2:0] funct3;
    logic       funct7_b5;

    assign funct3    = sub_op_code[2:0];
    assign funct7_b5 = sub_op_code[3];          // Selects SUB and SRA

    always_comb
    begin
        alu_op = ALU_ADD;                       // Address calc and everything else
        case (op_code)
            OPC_OP_IMM:
            begin
                case (funct3)
                    3'b000: alu_op = ALU_ADD;   // addi ignores bit 3
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLT;   // sltiu shares slti op
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: alu_op = funct7_b5 ? ALU_ADD : ALU_SLL; // 1001 undefined
                    3'b101: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_OP:
            begin
                case (funct3)
                    3'b000: alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLT;   // sltu, type comes from elsewhere
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OPC_BRANCH:
            begin
                case (funct3)
                    3'b000: alu_op = ALU_EQ;    // beq
                    3'b001: alu_op = ALU_NE;    // bne
                    3'b100: alu_op = ALU_LT;    // blt
                    3'b101: alu_op = ALU_GE;    // bge
                    3'b110: alu_op = ALU_LT;    // bltu
                    3'b111: alu_op = ALU_GE;    // bgeu
                    default: alu_op = ALU_ADD;  // funct3 010 and 011 reserved
                endcase
            end
            default:
            begin
                alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int OPCODE_W = 5;                 // Instruction bits 6:2
    localparam int SUB_OP_W = 4;                 // funct7[5] over funct3
    localparam int ALU_OP_W = 4;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    // Operation codes seen by the execute stage ALU
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLL = 4'd2,
        ALU_SRL = 4'd4,                          // Code 3 left unused
        ALU_SRA = 4'd5,
        ALU_XOR = 4'd6,
        ALU_OR  = 4'd7,
        ALU_AND = 4'd8,
        ALU_EQ  = 4'd9,                          // Branch compares
        ALU_NE  = 4'd10,
        ALU_LT  = 4'd11,
        ALU_GE  = 4'd12,
        ALU_SLT = 4'd13                          // Set less than, both forms
    } alu_op_e;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_LB   = 3'd1,
        LD_LBU  = 3'd2,
        LD_LH   = 3'd3,
        LD_LHU  = 3'd4,
        LD_LW   = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_SB   = 2'd1,
        ST_SH   = 2'd2,
        ST_SW   = 2'd3
    } store_type_e;

    // Next PC source for the fetch stage
    typedef enum logic [1:0] {
        PC_HOLD   = 2'b00,                       // No instruction
        PC_NEXT   = 2'b01,                       // PC plus 4
        PC_JUMP   = 2'b10,
        PC_BRANCH = 2'b11
    } pc_mode_e;

    // One issue slot as seen by decode
    typedef struct packed {
        logic                valid;
        opcode_e             op_code;
        logic [SUB_OP_W-1:0] sub_op_code;
    } slot_in_t;

    // Control word, MSB first as the EX stage expects it
    typedef struct packed {
        logic        imm_en;                     // Immediate as operand B
        logic        rf_write_en;
        logic        mem_read_en;
        logic        mem_write_en;
        logic        sign_ext_en;
        logic        sign_ext_unsigned;          // Zero extension when set
        logic        jal_en;
        logic        jalr_en;
        pc_mode_e    pc_mode;
        load_type_e  load_type;
        store_type_e store_type;
        alu_op_e     alu_op;
    } ctrl_t;

    // Registered slot at the ID/EX boundary
    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
    } slot_out_t;

endpackage

`default_nettype wire
